//--- verilog/stream_pkg.sv
// Stream package
// Word width of the input and output streams and the two views of an input beat

package stream_pkg;

  localparam int AXIS_W = 32;  // s_tdata and m_tdata width

  // Operand pair view, selected when s_tuser is low
  typedef struct packed {
    logic [15:0] rsvd;
    logic [7:0]  weight;
    logic [7:0]  feature;
  } mac_pair_t;

  // Bias view, selected when s_tuser is high
  typedef struct packed {
    logic [23:0] rsvd;
    logic [7:0]  bias;
  } bias_word_t;

  typedef union packed {
    mac_pair_t  mac_pair;
    bias_word_t bias_word;
  } beat_u;

endpackage

//--- verilog/arith_pkg.sv
// Arithmetic package
// Operand, product and accumulator widths of the MAC datapath

package arith_pkg;

  localparam int DATA_W = 8;  // Signed feature, weight and bias

  localparam int PROD_W = 2 * DATA_W;  // Full signed product

  // Default accumulator width, leaves room for long groups
  localparam int ACC_W = 28;

  // Bits per lookahead block
  localparam int CLA_GROUP = 4;

endpackage

//--- verilog/operand_if.sv
// Operand channel
// One feature/weight pair with its group sideband, ingress to multiplier

`timescale 1ns/1ns

interface operand_if import arith_pkg::*; ();

  logic                     valid;    // Pair enters this cycle
  logic signed [DATA_W-1:0] feature;
  logic signed [DATA_W-1:0] weight;
  logic                     first;    // Opens a group
  logic                     last;     // Closes a group
  logic signed [DATA_W-1:0] bias;     // Seed for the group

  modport src (output valid, feature, weight, first, last, bias);
  modport dst (input  valid, feature, weight, first, last, bias);

endinterface

//--- verilog/product_if.sv
// Product channel
// One signed product with its group sideband, multiplier to accumulator

`timescale 1ns/1ns

interface product_if import arith_pkg::*; ();

  logic                     valid;
  logic signed [PROD_W-1:0] product;
  logic                     first;    // Restart accumulation from bias
  logic                     last;     // Result goes out after this one
  logic signed [DATA_W-1:0] bias;

  modport src (output valid, product, first, last, bias);
  modport dst (input  valid, product, first, last, bias);

endinterface

//--- verilog/cla_block4.sv
// Four-bit carry-lookahead block
// Bit sums from local lookahead, plus group propagate/generate for the next level

`timescale 1ns/1ns

module cla_block4 import arith_pkg::*; (
  input  logic [CLA_GROUP-1:0] a,
  input  logic [CLA_GROUP-1:0] b,
  input  logic                 cin,
  output logic [CLA_GROUP-1:0] s,
  output logic                 pg,
  output logic                 gg
);

  logic [CLA_GROUP-1:0] p;
  logic [CLA_GROUP-1:0] g;
  logic [CLA_GROUP-1:0] c;  // Carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  // Carries straight from cin, no ripple
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);

  assign s = p ^ c;

  assign pg = &p;
  assign gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);

endmodule

//--- verilog/cla_adder.sv
// Carry-lookahead adder
// Four-bit blocks with a second lookahead level over runs of four blocks

`timescale 1ns/1ns

module cla_adder import arith_pkg::*; #(
  parameter int WIDTH = 28
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] s
);

  localparam int NBLK = WIDTH / CLA_GROUP;
  localparam int RUN  = 4;  // Blocks per group carry generator

  logic [NBLK-1:0] pg;
  logic [NBLK-1:0] gg;
  logic [NBLK-1:0] bc;  // Carry into each block

  ////////////////////
  // Group carries
  ////////////////////
  always_comb begin
    logic run_p;
    bc = '0;  // Carry-in of the whole adder is zero
    run_p = 1'b0;
    for (int r = 0; r < NBLK; r += RUN) begin
      for (int j = r; (j < r + RUN) && (j < NBLK - 1); j++) begin
        bc[j+1] = gg[j];
        run_p = pg[j];
        for (int k = j - 1; k >= r; k--) begin
          bc[j+1] = bc[j+1] | (run_p & gg[k]);
          run_p = run_p & pg[k];
        end
        bc[j+1] = bc[j+1] | (run_p & bc[r]);  // Run base carry from the run below
      end
    end
  end

  ////////////////////
  // Blocks
  ////////////////////
  for (genvar k = 0; k < NBLK; k++) begin : g_blk
    cla_block4 u_blk (
      .a   (a[k*CLA_GROUP +: CLA_GROUP]),
      .b   (b[k*CLA_GROUP +: CLA_GROUP]),
      .cin (bc[k]),
      .s   (s[k*CLA_GROUP +: CLA_GROUP]),
      .pg  (pg[k]),
      .gg  (gg[k])
    );
  end

endmodule

//--- verilog/stream_ingress.sv
// Stream ingress
// Splits input beats into bias updates and operand pairs, tracks group start

`timescale 1ns/1ns

module stream_ingress import stream_pkg::*; import arith_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  input  logic   s_tvalid,
  input  logic   s_tready,  // Pipeline advance from the top
  input  beat_u  s_tdata,
  input  logic   s_tuser,
  input  logic   s_tlast,
  operand_if.src op
);

  logic                     accept;
  logic signed [DATA_W-1:0] bias_q;      // Held bias for the next group
  logic                     first_pend;  // Next pair opens a group

  assign accept = s_tvalid & s_tready;

  // Bias beats stop here
  assign op.valid   = accept & ~s_tuser;
  assign op.feature = s_tdata.mac_pair.feature;
  assign op.weight  = s_tdata.mac_pair.weight;
  assign op.first   = first_pend;
  assign op.last    = s_tlast;
  assign op.bias    = bias_q;  // Only looked at with first

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bias_q     <= '0;
      first_pend <= 1'b1;
    end else if (accept) begin
      if (s_tuser) begin
        bias_q <= s_tdata.bias_word.bias;  // tlast ignored on bias beats
      end else begin
        first_pend <= s_tlast;
      end
    end
  end

endmodule

//--- verilog/pipe_mult.sv
// Pipelined signed multiplier
// Sign/magnitude shift-and-add over eight stages, group sideband carried alongside

`timescale 1ns/1ns

module pipe_mult import arith_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  input  logic   en,
  operand_if.dst op,
  product_if.src prod
);

  localparam int NSTAGE = 8;

  logic [DATA_W-1:0]              a_mag, b_mag;
  logic                           sign;
  logic [DATA_W-1:0][DATA_W-1:0]  pp, pp_q;    // Partial products
  logic [3:0][5:0]                lsb2, lsb2_q;
  logic [3:0][2:0]                hi2e_q;
  logic [3:0][3:0]                hi2o_q;
  logic [3:0][4:0]                msb3;
  logic [3:0][9:0]                sum3, sum3_q;
  logic [1:0][7:0]                lsb4, lsb4_q;
  logic [1:0][2:0]                hi4e_q;
  logic [1:0][4:0]                hi4o_q;
  logic [1:0][4:0]                msb5;
  logic [1:0][11:0]               sum5, sum5_q;
  logic [9:0]                     lsb6, lsb6_q;
  logic [2:0]                     hi6e_q;
  logic [6:0]                     hi6o_q;
  logic [6:0]                     msb7;
  logic [PROD_W-1:0]              sum_u, sum_u_q;
  logic [PROD_W-1:0]              prod_q;

  // Sideband, one entry per stage
  logic [NSTAGE-1:0]              v_q, first_q, last_q;
  logic [NSTAGE-1:0][DATA_W-1:0]  bias_q;
  logic [NSTAGE-2:0]              sign_q;

  ////////////////////
  // Stage 1
  ////////////////////
  assign a_mag = op.feature[DATA_W-1] ? -op.feature : op.feature;
  assign b_mag = op.weight[DATA_W-1]  ? -op.weight  : op.weight;
  assign sign  = op.feature[DATA_W-1] ^ op.weight[DATA_W-1];

  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      pp[i] = b_mag[i] ? a_mag : '0;
    end
  end

  ////////////////////
  // Stages 2 and 3
  ////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lsb2[i] = pp_q[2*i][4:0] + {pp_q[2*i+1][3:0], 1'b0};  // Shift by 1
      msb3[i] = hi2e_q[i] + hi2o_q[i] + lsb2_q[i][5];
      sum3[i] = {msb3[i], lsb2_q[i][4:0]};
    end
  end

  ////////////////////
  // Stages 4 to 7
  ////////////////////
  always_comb begin
    for (int j = 0; j < 2; j++) begin
      lsb4[j] = sum3_q[2*j][6:0] + {sum3_q[2*j+1][4:0], 2'b0};  // Shift by 2
      msb5[j] = hi4e_q[j] + hi4o_q[j] + lsb4_q[j][7];
      sum5[j] = {msb5[j], lsb4_q[j][6:0]};
    end
  end

  assign lsb6  = sum5_q[0][8:0] + {sum5_q[1][4:0], 4'b0};  // Shift by 4
  assign msb7  = hi6e_q + hi6o_q + lsb6_q[9];
  assign sum_u = {msb7, lsb6_q[8:0]};

  // Datapath registers
  always_ff @(posedge clk) begin
    if (en) begin
      pp_q <= pp;
      for (int i = 0; i < 4; i++) begin
        lsb2_q[i] <= lsb2[i];
        hi2e_q[i] <= pp_q[2*i][7:5];
        hi2o_q[i] <= pp_q[2*i+1][7:4];
      end
      sum3_q <= sum3;
      for (int j = 0; j < 2; j++) begin
        lsb4_q[j] <= lsb4[j];
        hi4e_q[j] <= sum3_q[2*j][9:7];
        hi4o_q[j] <= sum3_q[2*j+1][9:5];
      end
      sum5_q  <= sum5;
      lsb6_q  <= lsb6;
      hi6e_q  <= sum5_q[0][11:9];
      hi6o_q  <= sum5_q[1][11:5];
      sum_u_q <= sum_u;
      prod_q  <= sign_q[NSTAGE-2] ? -sum_u_q : sum_u_q;  // Stage 8 restores sign
      sign_q  <= {sign_q[NSTAGE-3:0], sign};
      first_q <= {first_q[NSTAGE-2:0], op.first};
      last_q  <= {last_q[NSTAGE-2:0], op.last};
      bias_q  <= {bias_q[NSTAGE-2:0], op.bias};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_q <= '0;
    end else if (en) begin
      v_q <= {v_q[NSTAGE-2:0], op.valid};
    end
  end

  assign prod.valid   = v_q[NSTAGE-1];
  assign prod.product = prod_q;
  assign prod.first   = first_q[NSTAGE-1];
  assign prod.last    = last_q[NSTAGE-1];
  assign prod.bias    = bias_q[NSTAGE-1];

endmodule

//--- verilog/mac_accum.sv
// Group accumulator
// Bias-seeded running sum per group and the output result register

`timescale 1ns/1ns

module mac_accum import stream_pkg::*; import arith_pkg::*; #(
  parameter int ACC_WIDTH = ACC_W
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              en,
  product_if.dst            prod,
  output logic              m_tvalid,
  output logic [AXIS_W-1:0] m_tdata
);

  logic [ACC_WIDTH-1:0] prod_ext;
  logic [ACC_WIDTH-1:0] seed;      // Bias on first, running sum otherwise
  logic [ACC_WIDTH-1:0] sum;
  logic [ACC_WIDTH-1:0] acc_q;
  logic                 acc_last_q;  // acc_q holds a finished group

  assign prod_ext = ACC_WIDTH'(prod.product);
  assign seed     = prod.first ? {{(ACC_WIDTH-DATA_W){prod.bias[DATA_W-1]}}, prod.bias}
                               : acc_q;

  cla_adder #(
    .WIDTH (ACC_WIDTH)
  ) u_cla_adder (
    .a (prod_ext),
    .b (seed),
    .s (sum)
  );

  ////////////////////
  // Accumulator
  ////////////////////
  always_ff @(posedge clk) begin
    if (en && prod.valid) begin
      acc_q <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_last_q <= 1'b0;
    end else if (en) begin
      acc_last_q <= prod.valid & prod.last;
    end
  end

  ////////////////////
  // Output register
  ////////////////////
  // en high with m_tvalid high means the current result is being taken
  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_tvalid <= 1'b0;
    end else if (en) begin
      m_tvalid <= acc_last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (en && acc_last_q) begin
      m_tdata <= AXIS_W'(signed'(acc_q));  // Sign-extend to the bus
    end
  end

endmodule

//--- verilog/conv_mac_top.sv
// Streaming MAC engine top
// Pair/bias stream in, one sign-extended result per group out, global stall

`timescale 1ns/1ns

module conv_mac_top import stream_pkg::*; import arith_pkg::*; #(
  parameter int ACC_WIDTH = ACC_W
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              s_tvalid,
  output logic              s_tready,
  input  logic [AXIS_W-1:0] s_tdata,
  input  logic              s_tuser,  // 1 for a bias beat
  input  logic              s_tlast,
  input  logic              m_tready,
  output logic              m_tvalid,
  output logic [AXIS_W-1:0] m_tdata
);

  logic en;  // Whole pipeline advances

  // Freeze everything while a result waits on the output
  assign en       = ~m_tvalid | m_tready;
  assign s_tready = en;

  operand_if u_op_if ();
  product_if u_prod_if ();

  stream_ingress u_stream_ingress (
    .clk      (clk),
    .rstn     (rstn),
    .s_tvalid (s_tvalid),
    .s_tready (en),
    .s_tdata  (s_tdata),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .op       (u_op_if.src)
  );

  pipe_mult u_pipe_mult (
    .clk  (clk),
    .rstn (rstn),
    .en   (en),
    .op   (u_op_if.dst),
    .prod (u_prod_if.src)
  );

  mac_accum #(
    .ACC_WIDTH (ACC_WIDTH)
  ) u_mac_accum (
    .clk      (clk),
    .rstn     (rstn),
    .en       (en),
    .prod     (u_prod_if.dst),
    .m_tvalid (m_tvalid),
    .m_tdata  (m_tdata)
  );

endmodule

//--- tb/conv_mac_checker.sv
// Result checker
// Compares each output handshake with the queued expected results

`timescale 1ns/1ns

module conv_mac_checker import stream_pkg::*; (
  input logic              clk,
  input logic              rstn,
  input logic              m_tvalid,
  input logic              m_tready,
  input logic [AXIS_W-1:0] m_tdata
);

  string             name_q[$];
  logic [AXIS_W-1:0] exp_q[$];
  int                value_errors = 0;
  int                other_errors = 0;
  logic              stalled_q = 1'b0;  // Result was held back on the last edge
  logic [AXIS_W-1:0] held_data;

  task automatic expect_result(input string name, input logic [AXIS_W-1:0] value);
    name_q.push_back(name);
    exp_q.push_back(value);
  endtask

  function automatic int outstanding();
    return exp_q.size();
  endfunction

  task automatic report_missing();
    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out, first missing is %s",
               exp_q.size(), name_q[0]);
      other_errors++;
    end
  endtask

  ////////////////////
  // Output watch
  ////////////////////
  always @(posedge clk) begin : compare
    string             name;
    logic [AXIS_W-1:0] exp;
    if (!rstn) begin
      stalled_q <= 1'b0;
    end else begin
      if (stalled_q && (m_tvalid !== 1'b1 || m_tdata !== held_data)) begin
        $display("Output result changed while stalled at %0t ns", $time);
        other_errors++;
      end
      if (m_tvalid === 1'b1 && m_tready === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Result %08h came out with nothing expected", m_tdata);
          other_errors++;
        end else begin
          name = name_q.pop_front();
          exp  = exp_q.pop_front();
          if (m_tdata !== exp) begin
            $display("FAILED %s: expected %08h, actual %08h", name, exp, m_tdata);
            value_errors++;
          end
        end
      end
      stalled_q <= (m_tvalid === 1'b1) && (m_tready !== 1'b1);
      held_data <= m_tdata;
    end
  end

endmodule

//--- tb/tb_conv_mac.sv
// MAC engine testbench
// Sends pair and bias beats, queues reference results and ends the run

`timescale 1ns/1ns

module tb_conv_mac import stream_pkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int N_GROUPS    = 20;
  localparam int GROUP_PAIRS = 9;
  // Latency pair, corners, random and stall runs, mid-bias pair of groups
  localparam int TOTAL_BEATS = 1 + 5 + 2 * N_GROUPS * (GROUP_PAIRS + 1) + 2 * (GROUP_PAIRS + 1);
  localparam int TIMEOUT_NS  = TOTAL_BEATS * 4 * CLK_PERIOD + 2000;

  logic              clk = 1'b0;
  logic              rstn;
  logic              s_tvalid;
  logic              s_tready;
  logic [AXIS_W-1:0] s_tdata;
  logic              s_tuser;
  logic              s_tlast;
  logic              m_tready;
  logic              m_tvalid;
  logic [AXIS_W-1:0] m_tdata;

  int                seed = 38440;
  int                tb_errors = 0;
  logic              stall_mode = 1'b0;  // Random gaps and back-pressure
  logic signed [7:0] cur_bias = '0;      // Bias the DUT holds for the next group
  logic signed [7:0] grp_f [0:15];
  logic signed [7:0] grp_w [0:15];

  always #(CLK_PERIOD / 2) clk = ~clk;

  conv_mac_top #(
    .ACC_WIDTH (28)
  ) u_conv_mac_top (
    .clk      (clk),
    .rstn     (rstn),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .m_tready (m_tready),
    .m_tvalid (m_tvalid),
    .m_tdata  (m_tdata)
  );

  conv_mac_checker u_conv_mac_checker (
    .clk      (clk),
    .rstn     (rstn),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata)
  );

  // Bias plus sum of signed products, wrapped to 28 bits
  function automatic logic [31:0] ref_group(input int n, input logic signed [7:0] bias);
    int          acc;
    logic [27:0] wrapped;
    acc = bias;
    for (int i = 0; i < n; i++) begin
      acc += grp_f[i] * grp_w[i];
    end
    wrapped = acc[27:0];
    return {{4{wrapped[27]}}, wrapped};
  endfunction

  task automatic send_beat(input logic [31:0] data, input logic user, input logic last);
    int gap;
    gap = stall_mode ? ($random(seed) & 3) : 0;
    repeat (gap) begin
      @(negedge clk);
      s_tvalid = 1'b0;
    end
    @(negedge clk);
    s_tvalid = 1'b1;
    s_tdata  = data;
    s_tuser  = user;
    s_tlast  = last;
    @(posedge clk);
    while (!s_tready) @(posedge clk);  // Taken on this edge
  endtask

  task automatic send_pair(input logic signed [7:0] f, input logic signed [7:0] w,
                           input logic last);
    send_beat({16'($random(seed)), w, f}, 1'b0, last);  // Junk in the unused bits
  endtask

  task automatic send_bias(input logic signed [7:0] b, input logic last);
    cur_bias = b;
    send_beat({24'($random(seed)), b}, 1'b1, last);
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      grp_f[i] = 8'($random(seed));
      grp_w[i] = 8'($random(seed));
    end
  endtask

  task automatic send_group(input string name, input int n);
    u_conv_mac_checker.expect_result(name, ref_group(n, cur_bias));
    for (int i = 0; i < n; i++) begin
      send_pair(grp_f[i], grp_w[i], i == n - 1);
    end
  endtask

  task automatic corner(input string name, input logic signed [7:0] f,
                        input logic signed [7:0] w);
    grp_f[0] = f;
    grp_w[0] = w;
    send_group(name, 1);
  endtask

  // Back-pressure, about one cycle in four while stalling
  always @(negedge clk) begin
    m_tready = stall_mode ? (($random(seed) & 3) != 0) : 1'b1;
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin : main
    int cycles;
    rstn     = 1'b0;
    s_tvalid = 1'b0;
    s_tdata  = '0;
    s_tuser  = 1'b0;
    s_tlast  = 1'b0;
    m_tready = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    @(negedge clk);
    if (m_tvalid !== 1'b0) begin
      $display("m_tvalid is not low after reset");
      tb_errors++;
    end
    if (s_tready !== 1'b1) begin
      $display("s_tready is not high after reset");
      tb_errors++;
    end
    corner("latency", 8'sd3, -8'sd7);
    @(negedge clk);
    s_tvalid = 1'b0;
    cycles = 1;  // The acceptance edge is the first one
    while (m_tvalid !== 1'b1 && cycles < 40) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles != 10) begin
      $display("Result came %0d cycles after acceptance instead of 10", cycles);
      tb_errors++;
    end

    corner("corner_min_min", -8'sd128, -8'sd128);
    corner("corner_min_max", -8'sd128, 8'sd127);
    corner("corner_zero", 8'sd0, 8'($random(seed)));
    corner("corner_one_neg", 8'sd1, -8'sd1);
    corner("corner_max_max", 8'sd127, 8'sd127);

    for (int g = 0; g < N_GROUPS; g++) begin
      send_bias(8'($random(seed)), 1'($random(seed)));
      fill_random(GROUP_PAIRS);
      send_group($sformatf("random_%0d", g), GROUP_PAIRS);
    end

    // Bias change inside a group only reaches the next group
    send_bias(8'sd25, 1'b0);
    fill_random(GROUP_PAIRS);
    u_conv_mac_checker.expect_result("mid_bias", ref_group(GROUP_PAIRS, cur_bias));
    for (int i = 0; i < 4; i++) begin
      send_pair(grp_f[i], grp_w[i], 1'b0);
    end
    send_bias(-8'sd60, 1'b1);  // tlast on a bias beat closes nothing
    for (int i = 4; i < GROUP_PAIRS; i++) begin
      send_pair(grp_f[i], grp_w[i], i == GROUP_PAIRS - 1);
    end
    fill_random(GROUP_PAIRS);
    send_group("after_mid_bias", GROUP_PAIRS);

    stall_mode = 1'b1;
    for (int g = 0; g < N_GROUPS; g++) begin
      send_bias(8'($random(seed)), 1'b0);
      fill_random(GROUP_PAIRS);
      send_group($sformatf("stall_%0d", g), GROUP_PAIRS);
    end
    @(negedge clk);
    s_tvalid   = 1'b0;
    stall_mode = 1'b0;

    while (u_conv_mac_checker.outstanding() != 0) @(negedge clk);
    repeat (20) @(negedge clk);  // Room for a duplicate to show up
    u_conv_mac_checker.report_missing();
    $display("Errors: %0d value mismatches, %0d other", u_conv_mac_checker.value_errors,
             u_conv_mac_checker.other_errors + tb_errors);
    if (u_conv_mac_checker.value_errors + u_conv_mac_checker.other_errors + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d results outstanding", TIMEOUT_NS,
             u_conv_mac_checker.outstanding());
    $display("Errors: %0d value mismatches, %0d other", u_conv_mac_checker.value_errors,
             u_conv_mac_checker.other_errors + tb_errors + 1);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- flist.f
verilog/stream_pkg.sv
verilog/arith_pkg.sv
verilog/operand_if.sv
verilog/product_if.sv
verilog/cla_block4.sv
verilog/cla_adder.sv
verilog/stream_ingress.sv
verilog/pipe_mult.sv
verilog/mac_accum.sv
verilog/conv_mac_top.sv
tb/conv_mac_checker.sv
tb/tb_conv_mac.sv

//--- Bender.yml
package:
  name: conv_mac

sources:
  - files:
      - verilog/stream_pkg.sv
      - verilog/arith_pkg.sv
      - verilog/operand_if.sv
      - verilog/product_if.sv
      - verilog/cla_block4.sv
      - verilog/cla_adder.sv
      - verilog/stream_ingress.sv
      - verilog/pipe_mult.sv
      - verilog/mac_accum.sv
      - verilog/conv_mac_top.sv
  - target: test
    files:
      - tb/conv_mac_checker.sv
      - tb/tb_conv_mac.sv
